// ==== cpu_core.f ====
hw/cpu_pkg.sv
hw/instr_decoder.sv
hw/branch_condition.sv
hw/register_file.sv
hw/control_sequencer.sv
hw/cpu_core.sv
+incdir+testbench
testbench/cpu_core_tb.sv

// ==== hw/branch_condition.sv ====
`timescale 1ns/1ps

module branch_condition (
   input  cpu_pkg::cond_t cond,
   input  cpu_pkg::word_t flags,
   output logic           cond_true
);
   import cpu_pkg::*;

   logic greater;
   logic lesser;
   logic equal;

   assign greater = flags[flag_greater];
   assign lesser  = flags[flag_lesser];
   assign equal   = flags[flag_equal];

   always_comb begin
      case (cond)
         4'd0:    cond_true = 1'b1;
         4'd1:    cond_true = equal;
         4'd2:    cond_true = !equal;
         4'd3:    cond_true = flags[flag_zero];
         4'd4:    cond_true = !flags[flag_zero];
         4'd5:    cond_true = flags[flag_carry];
         4'd6:    cond_true = !flags[flag_carry];
         4'd7:    cond_true = greater;
         4'd8:    cond_true = lesser;
         4'd9:    cond_true = greater | equal;
         4'd10:   cond_true = lesser | equal;
         4'd11:   cond_true = flags[flag_overflow];
         4'd12:   cond_true = !flags[flag_overflow];
         4'd13:   cond_true = flags[flag_negative];
         4'd14:   cond_true = flags[flag_div_zero];
         // code 15 is never taken
         default: cond_true = 1'b0;
      endcase
   end

endmodule

// ==== hw/control_sequencer.sv ====
`timescale 1ns/1ps

module control_sequencer (
   input  logic                  wire_clock,
   input  logic                  resetStage,
   input  cpu_pkg::word_t        mem_rdata,
   output cpu_pkg::word_t        mem_addr,
   output cpu_pkg::word_t        mem_wdata,
   output logic                  mem_we,
   output cpu_pkg::word_t        ir,
   input  cpu_pkg::instr_class_e instr_class,
   input  cpu_pkg::reg_idx_t     dst_idx,
   input  cpu_pkg::reg_idx_t     src_idx,
   input  logic [1:0]            mov_mode,
   input  logic                  cond_true,
   output cpu_pkg::reg_idx_t     rd_a_idx,
   output cpu_pkg::reg_idx_t     rd_b_idx,
   input  cpu_pkg::word_t        rd_a,
   input  cpu_pkg::word_t        rd_b,
   input  cpu_pkg::word_t        sp,
   output logic                  wr_en,
   output cpu_pkg::reg_idx_t     wr_idx,
   output cpu_pkg::word_t        wr_data,
   output logic                  sp_wr_en,
   output cpu_pkg::word_t        sp_wr_data
);
   import cpu_pkg::*;

   seq_state_e state;
   seq_state_e state_next;
   seq_state_e last_state;
   word_t      pc;
   word_t      addr_latch;
   logic       mem_strobe;

   // port a reads the source field, port b the destination field
   assign rd_a_idx = src_idx;
   assign rd_b_idx = dst_idx;
   assign wr_idx   = dst_idx;

   // final execute state of each class
   always_comb begin
      case (instr_class)
         ic_loadn, ic_loadi, ic_mov:   last_state = st_ex2;
         ic_storei, ic_push, ic_pop:   last_state = st_ex3;
         ic_load, ic_jmp, ic_rts:      last_state = st_ex4;
         ic_store:                     last_state = st_ex5;
         ic_call:                      last_state = st_ex7;
         default:                      last_state = st_ex1;
      endcase
   end

   always_comb begin
      case (state)
         st_fetch_addr: state_next = st_fetch_ir;
         st_fetch_ir:   state_next = st_ex1;
         st_ex1:        state_next = st_ex2;
         st_ex2:        state_next = st_ex3;
         st_ex3:        state_next = st_ex4;
         st_ex4:        state_next = st_ex5;
         st_ex5:        state_next = st_ex6;
         st_ex6:        state_next = st_ex7;
         default:       state_next = st_fetch_addr;
      endcase
      if (state == last_state) begin
         state_next = st_fetch_addr;
      end
   end

   // mem_we is registered, so the ram write lands one cycle after the strobe state
   assign mem_strobe = (state == st_ex2 && instr_class inside {ic_storei, ic_push, ic_call}) ||
                       (state == st_ex4 && instr_class == ic_store);

   // register and sp writes take effect at the end of the current state
   always_comb begin
      wr_en      = 1'b0;
      wr_data    = mem_rdata;
      sp_wr_en   = 1'b0;
      sp_wr_data = sp + 16'd1;
      case (instr_class)
         ic_loadn, ic_loadi: wr_en = (state == st_ex2);
         ic_load:            wr_en = (state == st_ex4);
         ic_pop: begin
            sp_wr_en = (state == st_ex1);
            wr_en    = (state == st_ex3);
         end
         ic_mov: begin
            // 11 loads sp, otherwise a register from rd_a or sp
            wr_en      = (state == st_ex1) && (mov_mode != 2'b11);
            wr_data    = mov_mode[0] ? sp : rd_a;
            sp_wr_en   = (state == st_ex1) && (mov_mode == 2'b11);
            sp_wr_data = rd_b;
         end
         ic_push: begin
            sp_wr_en   = (state == st_ex3);
            sp_wr_data = sp - 16'd1;
         end
         ic_call: begin
            // untaken call leaves sp alone even though the stack was written
            sp_wr_en   = (state == st_ex5) && cond_true;
            sp_wr_data = sp - 16'd1;
         end
         ic_rts:             sp_wr_en = (state == st_ex1);
         default:            wr_en = 1'b0;
      endcase
   end

   always_ff @(posedge wire_clock) begin
      if (resetStage) begin
         state    <= st_fetch_addr;
         pc       <= pc_reset_value;
         ir       <= '0;
         mem_addr <= '0;
         mem_we   <= 1'b0;
      end else begin
         state  <= state_next;
         mem_we <= mem_strobe;
         case (state)
            st_fetch_addr: mem_addr <= pc;
            st_fetch_ir: begin
               ir <= mem_rdata;
               pc <= pc + 16'd1;
            end
            default: begin
               case (instr_class)
                  ic_loadn, ic_load, ic_store, ic_jmp: begin
                     if (state == st_ex1) begin
                        mem_addr <= pc;
                     end
                     if (state == st_ex3 && instr_class inside {ic_load, ic_store}) begin
                        mem_addr <= addr_latch;
                     end
                  end
                  ic_loadi:          if (state == st_ex1) mem_addr <= rd_a;
                  ic_storei:         if (state == st_ex1) mem_addr <= rd_b;
                  ic_push:           if (state == st_ex1) mem_addr <= sp;
                  ic_pop:            if (state == st_ex2) mem_addr <= sp;
                  ic_call: begin
                     if (state == st_ex1) begin
                        mem_addr <= sp;
                     end
                     if (state == st_ex4) begin
                        mem_addr <= pc;
                     end
                  end
                  ic_rts: begin
                     if (state == st_ex2) begin
                        mem_addr <= sp;
                     end
                     if (state == st_ex3) begin
                        pc <= mem_rdata;
                     end
                  end
                  default:           mem_addr <= mem_addr;
               endcase

               // taken target is stored minus one, the later step adds it back
               if ((instr_class == ic_jmp && state == st_ex2) ||
                   (instr_class == ic_call && state == st_ex5)) begin
                  if (cond_true) begin
                     pc <= mem_rdata - 16'd1;
                  end
               end

               // step past the operand word or the return slot
               if ((instr_class == ic_loadn && state == st_ex2) ||
                   (instr_class == ic_load && state == st_ex4) ||
                   (instr_class == ic_store && state == st_ex5) ||
                   (instr_class == ic_jmp && state == st_ex3) ||
                   (instr_class == ic_call && state == st_ex6) ||
                   (instr_class == ic_rts && state == st_ex4)) begin
                  pc <= pc + 16'd1;
               end
            end
         endcase
      end
   end

   // operand address and write data
   always_ff @(posedge wire_clock) begin
      if (state == st_ex2 && instr_class inside {ic_load, ic_store}) begin
         addr_latch <= mem_rdata;
      end
      if (state == st_ex2 && instr_class == ic_storei) begin
         mem_wdata <= rd_a;
      end else if (state == st_ex2 && instr_class == ic_call) begin
         mem_wdata <= pc;
      end else if (mem_strobe) begin
         mem_wdata <= rd_b;
      end
   end

   a_no_we_in_fetch: assert property (
      @(posedge wire_clock) disable iff (resetStage)
         (state inside {st_fetch_addr, st_fetch_ir}) |-> !mem_we
   ) else $error("sequencer: mem_we high in fetch state %s", state.name());

   a_single_writer: assert property (
      @(posedge wire_clock) disable iff (resetStage)
         !(wr_en && mem_we)
   ) else $error("sequencer: register write and ram write together");

endmodule

// ==== hw/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core (
   input  logic           wire_clock,
   input  logic           resetStage,
   input  cpu_pkg::word_t mem_rdata,
   input  cpu_pkg::word_t flags,
   output cpu_pkg::word_t mem_addr,
   output cpu_pkg::word_t mem_wdata,
   output logic           mem_we
);
   import cpu_pkg::*;

   word_t        ir;
   instr_class_e instr_class;
   reg_idx_t     dst_idx;
   reg_idx_t     src_idx;
   cond_t        cond;
   logic [1:0]   mov_mode;
   logic         cond_true;
   reg_idx_t     rd_a_idx;
   reg_idx_t     rd_b_idx;
   word_t        rd_a;
   word_t        rd_b;
   word_t        sp;
   logic         wr_en;
   reg_idx_t     wr_idx;
   word_t        wr_data;
   logic         sp_wr_en;
   word_t        sp_wr_data;

   control_sequencer control_sequencer_i (
      .wire_clock  (wire_clock),
      .resetStage  (resetStage),
      .mem_rdata   (mem_rdata),
      .mem_addr    (mem_addr),
      .mem_wdata   (mem_wdata),
      .mem_we      (mem_we),
      .ir          (ir),
      .instr_class (instr_class),
      .dst_idx     (dst_idx),
      .src_idx     (src_idx),
      .mov_mode    (mov_mode),
      .cond_true   (cond_true),
      .rd_a_idx    (rd_a_idx),
      .rd_b_idx    (rd_b_idx),
      .rd_a        (rd_a),
      .rd_b        (rd_b),
      .sp          (sp),
      .wr_en       (wr_en),
      .wr_idx      (wr_idx),
      .wr_data     (wr_data),
      .sp_wr_en    (sp_wr_en),
      .sp_wr_data  (sp_wr_data)
   );

   instr_decoder instr_decoder_i (
      .ir          (ir),
      .instr_class (instr_class),
      .dst_idx     (dst_idx),
      .src_idx     (src_idx),
      .cond        (cond),
      .mov_mode    (mov_mode)
   );

   register_file register_file_i (
      .wire_clock  (wire_clock),
      .resetStage  (resetStage),
      .rd_a_idx    (rd_a_idx),
      .rd_b_idx    (rd_b_idx),
      .rd_a        (rd_a),
      .rd_b        (rd_b),
      .wr_en       (wr_en),
      .wr_idx      (wr_idx),
      .wr_data     (wr_data),
      .sp_wr_en    (sp_wr_en),
      .sp_wr_data  (sp_wr_data),
      .sp          (sp)
   );

   branch_condition branch_condition_i (
      .cond        (cond),
      .flags       (flags),
      .cond_true   (cond_true)
   );

endmodule

// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_idx_t;
   typedef logic [5:0]  opcode_t;
   typedef logic [3:0]  cond_t;

   // decoded instruction classes, anything unsupported lands on ic_nop
   typedef enum logic [3:0] {
      ic_nop,
      ic_loadn,
      ic_load,
      ic_store,
      ic_loadi,
      ic_storei,
      ic_mov,
      ic_push,
      ic_pop,
      ic_jmp,
      ic_call,
      ic_rts
   } instr_class_e;

   // two fetch cycles, then up to seven execute cycles
   typedef enum logic [3:0] {
      st_fetch_addr,
      st_fetch_ir,
      st_ex1,
      st_ex2,
      st_ex3,
      st_ex4,
      st_ex5,
      st_ex6,
      st_ex7
   } seq_state_e;

   // opcode field, IR bits 15..10
   localparam opcode_t op_loadn  = 6'b111000;
   localparam opcode_t op_load   = 6'b110000;
   localparam opcode_t op_store  = 6'b110001;
   localparam opcode_t op_loadi  = 6'b111100;
   localparam opcode_t op_storei = 6'b111101;
   localparam opcode_t op_mov    = 6'b110011;
   localparam opcode_t op_push   = 6'b000101;
   localparam opcode_t op_pop    = 6'b000110;
   localparam opcode_t op_jmp    = 6'b000010;
   localparam opcode_t op_call   = 6'b000011;
   localparam opcode_t op_rts    = 6'b000100;

   // bit positions in the flag word
   localparam int flag_greater  = 15;
   localparam int flag_lesser   = 14;
   localparam int flag_equal    = 13;
   localparam int flag_zero     = 12;
   localparam int flag_carry    = 11;
   localparam int flag_overflow = 10;
   localparam int flag_div_zero = 9;
   localparam int flag_negative = 6;

   localparam word_t sp_reset_value = 16'h7ffc;
   localparam word_t pc_reset_value = 16'h0000;

endpackage

// ==== hw/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
   input  cpu_pkg::word_t        ir,
   output cpu_pkg::instr_class_e instr_class,
   output cpu_pkg::reg_idx_t     dst_idx,
   output cpu_pkg::reg_idx_t     src_idx,
   output cpu_pkg::cond_t        cond,
   output logic [1:0]            mov_mode
);
   import cpu_pkg::*;

   opcode_t opcode;

   assign opcode = ir[15:10];

   always_comb begin
      case (opcode)
         op_loadn:  instr_class = ic_loadn;
         op_load:   instr_class = ic_load;
         op_store:  instr_class = ic_store;
         op_loadi:  instr_class = ic_loadi;
         op_storei: instr_class = ic_storei;
         op_mov:    instr_class = ic_mov;
         op_push:   instr_class = ic_push;
         op_pop:    instr_class = ic_pop;
         op_jmp:    instr_class = ic_jmp;
         op_call:   instr_class = ic_call;
         op_rts:    instr_class = ic_rts;
         // alu, io and flag stack opcodes retire as nop
         default:   instr_class = ic_nop;
      endcase
   end

   // register fields
   assign dst_idx = ir[9:7];
   assign src_idx = ir[6:4];

   // jmp/call condition overlaps the register fields
   assign cond = ir[9:6];

   // mov direction select
   assign mov_mode = ir[1:0];

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/1ps

module register_file (
   input  logic              wire_clock,
   input  logic              resetStage,
   input  cpu_pkg::reg_idx_t rd_a_idx,
   input  cpu_pkg::reg_idx_t rd_b_idx,
   output cpu_pkg::word_t    rd_a,
   output cpu_pkg::word_t    rd_b,
   input  logic              wr_en,
   input  cpu_pkg::reg_idx_t wr_idx,
   input  cpu_pkg::word_t    wr_data,
   input  logic              sp_wr_en,
   input  cpu_pkg::word_t    sp_wr_data,
   output cpu_pkg::word_t    sp
);
   import cpu_pkg::*;

   word_t regs [8];

   // asynchronous read for same-cycle use by the sequencer
   assign rd_a = regs[rd_a_idx];
   assign rd_b = regs[rd_b_idx];

   always_ff @(posedge wire_clock) begin
      if (resetStage) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_idx] <= wr_data;
      end
   end

   // stack pointer grows downward from the top of the data area
   always_ff @(posedge wire_clock) begin
      if (resetStage) begin
         sp <= sp_reset_value;
      end else if (sp_wr_en) begin
         sp <= sp_wr_data;
      end
   end

endmodule

// ==== run_sim.sh ====
#!/bin/bash
# build with Verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f cpu_core.f \
   --top-module cpu_core_tb -o cpu_core_sim > build.log 2>&1 \
   || { echo "build failed, see build.log"; exit 1; }
./obj_dir/cpu_core_sim > sim.log 2>&1
grep -q "Errors found" sim.log && { echo "simulation FAILED, see sim.log"; exit 1; }
grep -q "No errors" sim.log && echo "simulation passed" \
   || { echo "no result in sim.log"; exit 1; }

// ==== testbench/cpu_program.svh ====
function automatic logic [15:0] encode(input opcode_t op, input int dst, input int src,
                                       input int mode);
   return {op, dst[2:0], src[2:0], 2'b00, mode[1:0]};
endfunction

task automatic put_word(input logic [15:0] w);
   ram[load_ptr] = w;
   is_code[load_ptr] = 1'b1;
   load_ptr = load_ptr + 16'd1;
endtask

task automatic put_instr(input opcode_t op, input int dst, input int src, input int mode,
                         input int cycles);
   put_word(encode(op, dst, src, mode));
   budget_cycles = budget_cycles + 2 + cycles;
endtask

// each expected ram write queues its address and data
task automatic expect_write(input logic [15:0] addr, input logic [15:0] data);
   exp_addr.push_back(addr);
   exp_data.push_back(data);
   exp_marker.push_back(1'b0);
endtask

// data is decided at check time from the condition code and the flags
task automatic expect_marker(input int code);
   exp_addr.push_back(mark_base + 16'(code));
   exp_data.push_back(16'(code));
   exp_marker.push_back(1'b1);
endtask

task automatic emit_loadn(input int r, input logic [15:0] value);
   put_instr(op_loadn, r, 0, 0, 2);
   put_word(value);
endtask

task automatic emit_load(input int r, input logic [15:0] addr);
   put_instr(op_load, r, 0, 0, 4);
   put_word(addr);
endtask

task automatic emit_store(input logic [15:0] addr, input int r);
   put_instr(op_store, r, 0, 0, 5);
   put_word(addr);
endtask

// jmp and call carry the condition in the register fields
task automatic emit_branch(input opcode_t op, input int code, input logic [15:0] target,
                           input int cycles);
   put_word({op, code[3:0], 6'b000000});
   budget_cycles = budget_cycles + 2 + cycles;
   put_word(target);
endtask

task automatic build_program();
   logic [15:0] at;
   for (int i = 0; i < 65536; i++) begin
      ram[i] = 16'(i) ^ 16'hc3a5;
      is_code[i] = 1'b0;
   end
   load_ptr = 16'h0000;

   // immediate, direct and indirect moves
   emit_loadn(1, 16'h1234);
   emit_loadn(2, 16'h0800);
   emit_store(16'h0900, 1);
   expect_write(16'h0900, 16'h1234);
   emit_load(3, 16'h0900);
   put_instr(op_mov, 4, 3, 0, 2);
   put_instr(op_storei, 2, 4, 0, 3);
   expect_write(16'h0800, 16'h1234);
   emit_loadn(5, 16'hbeef);
   put_instr(op_storei, 2, 5, 0, 3);
   expect_write(16'h0800, 16'hbeef);
   put_instr(op_loadi, 7, 2, 0, 2);
   emit_store(16'h0901, 7);
   expect_write(16'h0901, 16'hbeef);

   // one conditional jump per code with the taken path at +8 and the join at +12
   for (int k = 0; k < 16; k++) begin
      at = load_ptr;
      emit_branch(op_jmp, k, at + 16'd8, 4);
      emit_loadn(1, nt_marker | 16'(k));
      emit_store(mark_base + 16'(k), 1);
      emit_branch(op_jmp, 0, at + 16'd12, 4);
      emit_loadn(1, tk_marker | 16'(k));
      emit_store(mark_base + 16'(k), 1);
      expect_marker(k);
   end

   // a never-taken call still writes its return slot
   at = load_ptr;
   emit_branch(op_call, 15, sub_addr, 7);
   expect_write(16'h7ffc, at + 16'd1);
   at = load_ptr;
   emit_branch(op_call, 0, sub_addr, 7);
   expect_write(16'h7ffc, at + 16'd1);
   expect_write(16'h0a01, 16'h7777);
   emit_loadn(1, 16'h5151);
   emit_store(16'h0a00, 1);
   expect_write(16'h0a00, 16'h5151);

   // push three and pop them in reverse
   emit_loadn(1, 16'h1111);
   emit_loadn(2, 16'h2222);
   emit_loadn(3, 16'h3333);
   put_instr(op_push, 1, 0, 0, 3);
   expect_write(16'h7ffc, 16'h1111);
   put_instr(op_push, 2, 0, 0, 3);
   expect_write(16'h7ffb, 16'h2222);
   put_instr(op_push, 3, 0, 0, 3);
   expect_write(16'h7ffa, 16'h3333);
   put_instr(op_pop, 4, 0, 0, 3);
   put_instr(op_pop, 5, 0, 0, 3);
   put_instr(op_pop, 6, 0, 0, 3);
   emit_store(16'h0b00, 4);
   expect_write(16'h0b00, 16'h3333);
   emit_store(16'h0b01, 5);
   expect_write(16'h0b01, 16'h2222);
   emit_store(16'h0b02, 6);
   expect_write(16'h0b02, 16'h1111);

   // move the stack to 4000, push there, read sp back
   emit_loadn(7, 16'h4000);
   put_instr(op_mov, 7, 0, 3, 2);
   put_instr(op_push, 1, 0, 0, 3);
   expect_write(16'h4000, 16'h1111);
   put_instr(op_mov, 0, 0, 1, 2);
   emit_store(16'h0b03, 0);
   expect_write(16'h0b03, 16'h3fff);

   // park
   at = load_ptr;
   emit_branch(op_jmp, 0, at, 4);

   // subroutine
   load_ptr = sub_addr;
   emit_loadn(1, 16'h7777);
   emit_store(16'h0a01, 1);
   put_instr(op_rts, 0, 0, 0, 4);
endtask

// ==== testbench/cpu_core_tb.sv ====
`timescale 1ns/1ps

module cpu_core_tb;
   import cpu_pkg::*;

   localparam logic [15:0] mark_base = 16'h0c00;
   localparam logic [15:0] tk_marker = 16'ha000;
   localparam logic [15:0] nt_marker = 16'hb000;
   localparam logic [15:0] sub_addr  = 16'h0f00;

   logic  wire_clock;
   logic  resetStage;
   word_t mem_rdata;
   word_t flags;
   word_t mem_addr;
   word_t mem_wdata;
   logic  mem_we;

   logic [15:0] ram [65536];
   bit          is_code [65536];
   logic [15:0] load_ptr;
   int          budget_cycles;
   bit          program_ready;
   int          seed;

   logic [15:0] exp_addr [$];
   logic [15:0] exp_data [$];
   bit          exp_marker [$];
   logic [15:0] want_addr;
   logic [15:0] want_data;
   bit          want_marker;

   `include "cpu_program.svh"

   cpu_core cpu_core_i (
      .wire_clock (wire_clock),
      .resetStage (resetStage),
      .mem_rdata  (mem_rdata),
      .flags      (flags),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_we     (mem_we)
   );

   task automatic report_mismatch(input string name, input logic [15:0] got,
                                  input logic [15:0] want);
      $display("FAIL %s got %h expected %h", name, got, want);
      $display("Errors found");
      $fatal(1, "stopped at first mismatch");
   endtask

   task automatic report_problem(input string text);
      $display("%s", text);
      $display("Errors found");
      $fatal(1, "stopped");
   endtask

   // condition table of the jump and call instructions
   function automatic logic branch_taken(input int code, input logic [15:0] f);
      case (code)
         0:       return 1'b1;
         1:       return f[flag_equal];
         2:       return !f[flag_equal];
         3:       return f[flag_zero];
         4:       return !f[flag_zero];
         5:       return f[flag_carry];
         6:       return !f[flag_carry];
         7:       return f[flag_greater];
         8:       return f[flag_lesser];
         9:       return f[flag_greater] || f[flag_equal];
         10:      return f[flag_lesser] || f[flag_equal];
         11:      return f[flag_overflow];
         12:      return !f[flag_overflow];
         13:      return f[flag_negative];
         14:      return f[flag_div_zero];
         default: return 1'b0;
      endcase
   endfunction

   initial begin
      wire_clock = 1'b0;
      forever #50 wire_clock = ~wire_clock;
   end

   // ram model with asynchronous read
   assign mem_rdata = ram[mem_addr];

   always @(posedge wire_clock) begin
      if (mem_we) begin
         ram[mem_addr] <= mem_wdata;
      end
   end

   // every ram write is compared in program order
   always @(posedge wire_clock) begin
      if (!resetStage && mem_we) begin
         if (exp_addr.size() == 0) begin
            report_problem("RAM write seen after the last expected write");
         end else begin
            want_addr = exp_addr.pop_front();
            want_data = exp_data.pop_front();
            want_marker = exp_marker.pop_front();
            // flags were held since the previous write, so they decided the jump
            if (want_marker) begin
               want_data = branch_taken(int'(want_data), flags) ?
                           (tk_marker | want_data) : (nt_marker | want_data);
            end
            assert (mem_addr == want_addr)
               else report_mismatch("mem_addr", mem_addr, want_addr);
            assert (mem_wdata == want_data)
               else report_mismatch("mem_wdata", mem_wdata, want_data);
            flags <= $random(seed);
         end
      end
   end

   a_quiet_in_reset: assert property (
      @(posedge wire_clock) resetStage |=> !mem_we
   ) else report_mismatch("mem_we", 16'($sampled(mem_we)), 16'h0000);

   a_no_write_on_code: assert property (
      @(posedge wire_clock) disable iff (resetStage) !(mem_we && is_code[mem_addr])
   ) else report_problem($sformatf("RAM write to program word at %h", $sampled(mem_addr)));

   initial begin
      wait (program_ready);
      repeat (8 + budget_cycles + 100) @(posedge wire_clock);
      report_problem("timeout, program did not finish its stores");
   end

   initial begin
      seed = 32'h522e;
      resetStage = 1'b1;
      flags = 16'h0000;
      budget_cycles = 0;
      program_ready = 1'b0;
      build_program();
      program_ready = 1'b1;
      flags = $random(seed);
      repeat (8) @(posedge wire_clock);
      resetStage <= 1'b0;
      // first fetch address is visible during the second cycle
      @(posedge wire_clock);
      @(negedge wire_clock);
      assert (mem_addr == 16'h0000)
         else report_mismatch("mem_addr", mem_addr, 16'h0000);
      assert (!mem_we)
         else report_mismatch("mem_we", 16'(mem_we), 16'h0000);
      while (exp_addr.size() != 0) begin
         @(posedge wire_clock);
      end
      repeat (2) @(posedge wire_clock);
      $display("No errors");
      $finish;
   end

endmodule
